// File: verilog/global_buffer_params.svh
`ifndef GLOBAL_BUFFER_PARAMS_SVH
`define GLOBAL_BUFFER_PARAMS_SVH

// tile chain and load queue
`define GLB_NUM_TILES 4
`define GLB_QUEUE_DEPTH 2

// configuration bus
`define GLB_TILE_SEL_WIDTH 4
`define GLB_CFG_ADDR_WIDTH 12
`define GLB_CFG_DATA_WIDTH 32

// address fields: tile in [10:7], register word in [6:2]
`define GLB_CFG_TILE_LSB 7
`define GLB_CFG_REG_LSB 2
`define GLB_CFG_REG_WIDTH 5

// buffer side
`define GLB_ADDR_WIDTH 16
`define GLB_NUM_WORDS_WIDTH 8

`endif

// File: verilog/global_buffer_pkg.sv
`default_nettype none

`include "global_buffer_params.svh"

package global_buffer_pkg;

    typedef logic [`GLB_TILE_SEL_WIDTH-1:0]  tile_id_t;
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_data_t;
    typedef logic [`GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [`GLB_NUM_WORDS_WIDTH-1:0] num_words_t;

    // configuration write, one-cycle strobe
    typedef struct packed {
        logic      wr_en;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

    typedef struct packed {
        logic      rd_en;
        cfg_addr_t addr;
    } cfg_rd_req_t;

    typedef struct packed {
        logic      rd_data_valid;
        cfg_data_t rd_data;
    } cfg_rd_rsp_t;

    // one load queue entry
    typedef struct packed {
        logic       valid;
        glb_addr_t  start_addr;
        num_words_t num_words;
    } dma_ld_header_t;

    typedef enum logic {
        IDLE,
        RUN
    } ld_dma_state_t;

endpackage

`default_nettype wire

// File: verilog/glb_tile_cfg.sv
`timescale 1ns/10ps
`default_nettype none

`include "global_buffer_params.svh"

module glb_tile_cfg #(
    parameter global_buffer_pkg::tile_id_t TILE_ID = '0
) (
    input  wire logic                                               clk,
    input  wire logic                                               reset,
    input  wire global_buffer_pkg::cfg_wr_t                         cfg_wr,
    input  wire global_buffer_pkg::cfg_rd_req_t                     cfg_rd_req,
    input  wire logic [`GLB_QUEUE_DEPTH-1:0]                        ld_invalidate_pulse,
    output logic                                                    wr_claim,
    output logic                                                    rd_claim,
    output global_buffer_pkg::cfg_data_t                            rd_data,
    output logic                                                    ld_dma_on,
    output global_buffer_pkg::dma_ld_header_t [`GLB_QUEUE_DEPTH-1:0] ld_header
);

    global_buffer_pkg::tile_id_t   wr_tile;
    global_buffer_pkg::tile_id_t   rd_tile;
    logic [`GLB_CFG_REG_WIDTH-1:0] wr_reg;
    logic [`GLB_CFG_REG_WIDTH-1:0] rd_reg;

    // address field decode
    assign wr_tile = cfg_wr.addr[`GLB_CFG_TILE_LSB +: `GLB_TILE_SEL_WIDTH];
    assign wr_reg  = cfg_wr.addr[`GLB_CFG_REG_LSB +: `GLB_CFG_REG_WIDTH];
    assign rd_tile = cfg_rd_req.addr[`GLB_CFG_TILE_LSB +: `GLB_TILE_SEL_WIDTH];
    assign rd_reg  = cfg_rd_req.addr[`GLB_CFG_REG_LSB +: `GLB_CFG_REG_WIDTH];

    assign wr_claim = cfg_wr.wr_en && (wr_tile == TILE_ID);
    assign rd_claim = cfg_rd_req.rd_en && (rd_tile == TILE_ID);

    // register 0 is dma_on, then a num_words / start+valid pair per entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ld_dma_on <= 1'b0;
            ld_header <= '0;
        end else begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (ld_invalidate_pulse[i]) begin
                    ld_header[i].valid <= 1'b0;
                end
            end

            // placed after the clear so a same-cycle write wins
            if (wr_claim) begin
                if (wr_reg == '0) begin
                    ld_dma_on <= cfg_wr.data[0];
                end
                for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                    if (wr_reg == `GLB_CFG_REG_WIDTH'(2 * i + 1)) begin
                        ld_header[i].num_words <= cfg_wr.data[`GLB_NUM_WORDS_WIDTH-1:0];
                    end
                    if (wr_reg == `GLB_CFG_REG_WIDTH'(2 * i + 2)) begin
                        {ld_header[i].start_addr, ld_header[i].valid} <=
                            cfg_wr.data[`GLB_ADDR_WIDTH:0];
                    end
                end
            end
        end
    end

    // read mux, unmapped words read as zero
    always_comb begin
        rd_data = '0;
        if (rd_claim) begin
            if (rd_reg == '0) begin
                rd_data[0] = ld_dma_on;
            end
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (rd_reg == `GLB_CFG_REG_WIDTH'(2 * i + 1)) begin
                    rd_data[`GLB_NUM_WORDS_WIDTH-1:0] = ld_header[i].num_words;
                end
                if (rd_reg == `GLB_CFG_REG_WIDTH'(2 * i + 2)) begin
                    rd_data[`GLB_ADDR_WIDTH:0] = {ld_header[i].start_addr, ld_header[i].valid};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/glb_cfg_router.sv
`timescale 1ns/10ps
`default_nettype none

module glb_cfg_router (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire global_buffer_pkg::cfg_wr_t     wst_wr,
    input  wire global_buffer_pkg::cfg_rd_req_t wst_rd_req,
    input  wire logic                           wr_claim,
    input  wire logic                           rd_claim,
    input  wire global_buffer_pkg::cfg_data_t   rd_data,
    input  wire global_buffer_pkg::cfg_rd_rsp_t est_rd_rsp,
    output global_buffer_pkg::cfg_wr_t          est_wr,
    output global_buffer_pkg::cfg_rd_req_t      est_rd_req,
    output global_buffer_pkg::cfg_rd_rsp_t      wst_rd_rsp
);

    // write path eastward
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_wr <= '0;
        end else if (wst_wr.wr_en && !wr_claim) begin
            est_wr <= wst_wr;
        end else begin
            est_wr <= '0;
        end
    end

    // read request eastward
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_rd_req <= '0;
        end else if (wst_rd_req.rd_en && !rd_claim) begin
            est_rd_req <= wst_rd_req;
        end else begin
            est_rd_req <= '0;
        end
    end

    // response westward, local data takes the slot when claimed here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wst_rd_rsp <= '0;
        end else if (rd_claim) begin
            wst_rd_rsp.rd_data_valid <= 1'b1;
            wst_rd_rsp.rd_data       <= rd_data;
        end else begin
            wst_rd_rsp <= est_rd_rsp;
        end
    end

endmodule

`default_nettype wire

// File: verilog/glb_ld_dma.sv
`timescale 1ns/10ps
`default_nettype none

`include "global_buffer_params.svh"

module glb_ld_dma (
    input  wire logic                                                   clk,
    input  wire logic                                                   reset,
    input  wire logic                                                   ld_dma_on,
    input  wire global_buffer_pkg::dma_ld_header_t [`GLB_QUEUE_DEPTH-1:0] ld_header,
    output logic [`GLB_QUEUE_DEPTH-1:0]                                 ld_invalidate_pulse,
    output logic                                                        ld_addr_valid,
    output global_buffer_pkg::glb_addr_t                                ld_addr
);

    localparam int PTR_WIDTH  = (`GLB_QUEUE_DEPTH > 1) ? $clog2(`GLB_QUEUE_DEPTH) : 1;
    localparam int LAST_ENTRY = `GLB_QUEUE_DEPTH - 1;

    global_buffer_pkg::ld_dma_state_t  state;
    logic [PTR_WIDTH-1:0]              q_ptr;
    global_buffer_pkg::num_words_t     word_cnt;
    global_buffer_pkg::glb_addr_t      addr_r;
    global_buffer_pkg::dma_ld_header_t cur_header;
    logic                              start;
    logic                              skip;
    logic                              last_word;
    logic                              done;

    assign cur_header = ld_header[q_ptr];
    assign start      = (state == global_buffer_pkg::IDLE) && ld_dma_on && cur_header.valid;
    // empty entry is retired straight from IDLE
    assign skip       = start && (cur_header.num_words == '0);
    assign last_word  = (state == global_buffer_pkg::RUN) &&
                        (word_cnt == global_buffer_pkg::num_words_t'(1));
    assign done       = skip || last_word;

    always_comb begin
        ld_invalidate_pulse        = '0;
        ld_invalidate_pulse[q_ptr] = done;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= global_buffer_pkg::IDLE;
            q_ptr    <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                global_buffer_pkg::IDLE: begin
                    if (start && !skip) begin
                        state    <= global_buffer_pkg::RUN;
                        word_cnt <= cur_header.num_words;
                    end
                end
                global_buffer_pkg::RUN: begin
                    word_cnt <= word_cnt - 1'b1;
                    if (last_word) begin
                        state <= global_buffer_pkg::IDLE;
                    end
                end
                default: state <= global_buffer_pkg::IDLE;
            endcase

            if (done) begin
                q_ptr <= (q_ptr == PTR_WIDTH'(LAST_ENTRY)) ? '0 : q_ptr + 1'b1;
            end
        end
    end

    // tracks start_addr while idle, counts up while running
    always_ff @(posedge clk) begin
        if (state == global_buffer_pkg::IDLE) begin
            addr_r <= cur_header.start_addr;
        end else begin
            addr_r <= addr_r + 1'b1;
        end
    end

    assign ld_addr_valid = (state == global_buffer_pkg::RUN);
    assign ld_addr       = addr_r;

endmodule

`default_nettype wire

// File: verilog/glb_tile.sv
`timescale 1ns/10ps
`default_nettype none

`include "global_buffer_params.svh"

module glb_tile #(
    parameter global_buffer_pkg::tile_id_t TILE_ID = '0
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire global_buffer_pkg::cfg_wr_t     wst_wr,
    input  wire global_buffer_pkg::cfg_rd_req_t wst_rd_req,
    input  wire global_buffer_pkg::cfg_rd_rsp_t est_rd_rsp,
    output global_buffer_pkg::cfg_wr_t          est_wr,
    output global_buffer_pkg::cfg_rd_req_t      est_rd_req,
    output global_buffer_pkg::cfg_rd_rsp_t      wst_rd_rsp,
    output logic                                ld_addr_valid,
    output global_buffer_pkg::glb_addr_t        ld_addr
);

    logic                                                   wr_claim;
    logic                                                   rd_claim;
    global_buffer_pkg::cfg_data_t                           rd_data;
    logic                                                   ld_dma_on;
    global_buffer_pkg::dma_ld_header_t [`GLB_QUEUE_DEPTH-1:0] ld_header;
    logic [`GLB_QUEUE_DEPTH-1:0]                            ld_invalidate_pulse;

    glb_tile_cfg #(
        .TILE_ID (TILE_ID)
    ) u_cfg (
        .clk                 (clk),
        .reset               (reset),
        .cfg_wr              (wst_wr),
        .cfg_rd_req          (wst_rd_req),
        .ld_invalidate_pulse (ld_invalidate_pulse),
        .wr_claim            (wr_claim),
        .rd_claim            (rd_claim),
        .rd_data             (rd_data),
        .ld_dma_on           (ld_dma_on),
        .ld_header           (ld_header)
    );

    glb_cfg_router u_router (
        .clk        (clk),
        .reset      (reset),
        .wst_wr     (wst_wr),
        .wst_rd_req (wst_rd_req),
        .wr_claim   (wr_claim),
        .rd_claim   (rd_claim),
        .rd_data    (rd_data),
        .est_rd_rsp (est_rd_rsp),
        .est_wr     (est_wr),
        .est_rd_req (est_rd_req),
        .wst_rd_rsp (wst_rd_rsp)
    );

    glb_ld_dma u_ld_dma (
        .clk                 (clk),
        .reset               (reset),
        .ld_dma_on           (ld_dma_on),
        .ld_header           (ld_header),
        .ld_invalidate_pulse (ld_invalidate_pulse),
        .ld_addr_valid       (ld_addr_valid),
        .ld_addr             (ld_addr)
    );

endmodule

`default_nettype wire

// File: verilog/glb_tile_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "global_buffer_params.svh"

module glb_tile_array (
    input  wire logic                                            clk,
    input  wire logic                                            reset,
    input  wire global_buffer_pkg::cfg_wr_t                      cfg_wr,
    input  wire global_buffer_pkg::cfg_rd_req_t                  cfg_rd_req,
    output global_buffer_pkg::cfg_rd_rsp_t                       cfg_rd_rsp,
    output wire logic [`GLB_NUM_TILES-1:0]                       ld_addr_valid,
    output wire global_buffer_pkg::glb_addr_t [`GLB_NUM_TILES-1:0] ld_addr
);

    // index k is the west side of tile k
    wire global_buffer_pkg::cfg_wr_t     [`GLB_NUM_TILES:0] wr_chain;
    wire global_buffer_pkg::cfg_rd_req_t [`GLB_NUM_TILES:0] rd_req_chain;
    wire global_buffer_pkg::cfg_rd_rsp_t [`GLB_NUM_TILES:0] rd_rsp_chain;

    assign wr_chain[0]                 = cfg_wr;
    assign rd_req_chain[0]             = cfg_rd_req;
    // nothing east of the last tile
    assign rd_rsp_chain[`GLB_NUM_TILES] = '0;
    assign cfg_rd_rsp                  = rd_rsp_chain[0];

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (global_buffer_pkg::tile_id_t'(i))
        ) u_tile (
            .clk           (clk),
            .reset         (reset),
            .wst_wr        (wr_chain[i]),
            .wst_rd_req    (rd_req_chain[i]),
            .est_rd_rsp    (rd_rsp_chain[i+1]),
            .est_wr        (wr_chain[i+1]),
            .est_rd_req    (rd_req_chain[i+1]),
            .wst_rd_rsp    (rd_rsp_chain[i]),
            .ld_addr_valid (ld_addr_valid[i]),
            .ld_addr       (ld_addr[i])
        );
    end

endmodule

`default_nettype wire

// File: verification/glb_tile_array_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "global_buffer_params.svh"

module glb_tile_array_props (
    input wire logic                             clk,
    input wire logic                             reset,
    input wire global_buffer_pkg::ld_dma_state_t state,
    input wire logic [`GLB_QUEUE_DEPTH-1:0]      ld_invalidate_pulse,
    input wire logic                             ld_addr_valid,
    input wire global_buffer_pkg::glb_addr_t     ld_addr
);

    a_invalidate_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ld_invalidate_pulse))
        else $error("more than one load entry invalidated in a cycle");

    // an entry is retired by a single pulse
    a_invalidate_single: assert property (@(posedge clk) disable iff (reset)
        |ld_invalidate_pulse |=> (ld_invalidate_pulse & $past(ld_invalidate_pulse)) == '0)
        else $error("invalidate pulse held for more than one cycle");

    a_addr_step: assert property (@(posedge clk) disable iff (reset)
        (state == global_buffer_pkg::RUN) |=> (state != global_buffer_pkg::RUN) ||
        (ld_addr == global_buffer_pkg::glb_addr_t'($past(ld_addr) + 1'b1)))
        else $error("load address did not step by one while running");

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == global_buffer_pkg::IDLE) |-> !ld_addr_valid)
        else $error("load address valid while the DMA is idle");

endmodule

bind glb_ld_dma glb_tile_array_props u_props (
    .clk                 (clk),
    .reset               (reset),
    .state               (state),
    .ld_invalidate_pulse (ld_invalidate_pulse),
    .ld_addr_valid       (ld_addr_valid),
    .ld_addr             (ld_addr)
);

`default_nettype wire

// File: verification/tb_glb_tile_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "global_buffer_params.svh"

module tb_glb_tile_array;

    localparam int NUM_TILES = `GLB_NUM_TILES;
    localparam int NUM_REGS  = 1 + 2 * `GLB_QUEUE_DEPTH;
    localparam int MAX_EXP   = 32;
    // reads, writes and DMA runs take about 850 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                                                      clk = 1'b0;
    logic                                                      reset;
    global_buffer_pkg::cfg_wr_t                                cfg_wr;
    global_buffer_pkg::cfg_rd_req_t                            cfg_rd_req;
    global_buffer_pkg::cfg_rd_rsp_t                            cfg_rd_rsp;
    logic [`GLB_NUM_TILES-1:0]                                 ld_addr_valid;
    global_buffer_pkg::glb_addr_t [`GLB_NUM_TILES-1:0]         ld_addr;

    integer                       seed = 32'h8f6d_f2e0;
    int                           cycle_cnt;
    global_buffer_pkg::cfg_data_t shadow [NUM_TILES][NUM_REGS];
    global_buffer_pkg::glb_addr_t exp_addr [NUM_TILES][MAX_EXP];
    int                           exp_wr [NUM_TILES];
    int                           exp_rd [NUM_TILES];
    global_buffer_pkg::cfg_data_t rd_expected;
    int                           rd_expected_lat;
    int                           rd_issue_cycle;
    int                           rd_issued;
    int                           rd_answered;

    glb_tile_array DUT (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr        (cfg_wr),
        .cfg_rd_req    (cfg_rd_req),
        .cfg_rd_rsp    (cfg_rd_rsp),
        .ld_addr_valid (ld_addr_valid),
        .ld_addr       (ld_addr)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic global_buffer_pkg::cfg_addr_t reg_addr(input int t, input int r);
        global_buffer_pkg::cfg_addr_t a;
        a = '0;
        a[`GLB_CFG_TILE_LSB +: `GLB_TILE_SEL_WIDTH] = global_buffer_pkg::tile_id_t'(t);
        a[`GLB_CFG_REG_LSB +: `GLB_CFG_REG_WIDTH]   = `GLB_CFG_REG_WIDTH'(r);
        return a;
    endfunction

    // expected read value from the shadow registers
    function automatic global_buffer_pkg::cfg_data_t expected_read(input int t, input int r);
        global_buffer_pkg::cfg_data_t v;
        v = '0;
        if (r == 0) begin
            v[0] = shadow[t][0][0];
        end else if (r < NUM_REGS && (r % 2) == 1) begin
            v[`GLB_NUM_WORDS_WIDTH-1:0] = shadow[t][r][`GLB_NUM_WORDS_WIDTH-1:0];
        end else if (r < NUM_REGS) begin
            v[`GLB_ADDR_WIDTH:0] = shadow[t][r][`GLB_ADDR_WIDTH:0];
        end
        return v;
    endfunction

    // start_addr sits above the valid bit
    function automatic global_buffer_pkg::glb_addr_t expected_addr(input int t, input int e,
                                                                   input int i);
        global_buffer_pkg::cfg_data_t hdr;
        hdr = shadow[t][2 + 2 * e];
        return global_buffer_pkg::glb_addr_t'(hdr[`GLB_ADDR_WIDTH:1] + i);
    endfunction

    task automatic queue_entry_addrs(input int t, input int e);
        int n;
        n = int'(shadow[t][1 + 2 * e][`GLB_NUM_WORDS_WIDTH-1:0]);
        if (shadow[t][2 + 2 * e][0]) begin
            for (int i = 0; i < n; i++) begin
                exp_addr[t][exp_wr[t]] = expected_addr(t, e, i);
                exp_wr[t] = exp_wr[t] + 1;
            end
        end
    endtask

    task automatic write_reg(input int t, input int r, input global_buffer_pkg::cfg_data_t d);
        global_buffer_pkg::cfg_wr_t w;
        w.wr_en = 1'b1;
        w.addr  = reg_addr(t, r);
        w.data  = d;
        @(posedge clk);
        cfg_wr <= w;
        if (t < NUM_TILES && r < NUM_REGS) begin
            shadow[t][r] = d;
        end
        @(posedge clk);
        cfg_wr <= '0;
    endtask

    task automatic read_check(input int t, input int r);
        global_buffer_pkg::cfg_rd_req_t req;
        req.rd_en = 1'b1;
        req.addr  = reg_addr(t, r);
        @(posedge clk);
        cfg_rd_req <= req;
        rd_expected     = expected_read(t, r);
        rd_expected_lat = 2 * t + 1;
        // cycle 0 starts at this edge and the counter steps here as well
        rd_issue_cycle  = cycle_cnt + 1;
        rd_issued       = rd_issued + 1;
        @(posedge clk);
        cfg_rd_req <= '0;
        while (rd_answered != rd_issued) begin
            @(posedge clk);
        end
    endtask

    task automatic read_all_regs();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                read_check(t, r);
            end
        end
    endtask

    task automatic wait_dma_drain();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = 1'b0;
            for (int t = 0; t < NUM_TILES; t++) begin
                if (exp_rd[t] != exp_wr[t]) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // read responses sampled on the falling edge
    always @(negedge clk) begin
        if (!reset && cfg_rd_rsp.rd_data_valid) begin
            if (rd_answered == rd_issued) begin
                fail_run("read response arrived with no read outstanding");
            end
            check_value("cfg_rd_rsp.rd_data", cfg_rd_rsp.rd_data, rd_expected);
            check_value("read latency", 32'(cycle_cnt - rd_issue_cycle), 32'(rd_expected_lat));
            rd_answered = rd_answered + 1;
        end
    end

    // load address streams per tile
    always @(negedge clk) begin
        if (!reset) begin
            for (int t = 0; t < NUM_TILES; t++) begin
                if (ld_addr_valid[t]) begin
                    if (exp_rd[t] >= exp_wr[t]) begin
                        fail_run($sformatf("tile %0d emitted load address 0x%04h unexpectedly",
                                           t, ld_addr[t]));
                    end
                    check_value($sformatf("ld_addr[%0d]", t), 32'(ld_addr[t]),
                                32'(exp_addr[t][exp_rd[t]]));
                    exp_rd[t] = exp_rd[t] + 1;
                end
            end
        end
    end

    initial begin
        global_buffer_pkg::cfg_data_t d;
        int t;
        int r;
        int e;
        reset      = 1'b1;
        cfg_wr     = '0;
        cfg_rd_req = '0;
        for (t = 0; t < NUM_TILES; t++) begin
            for (r = 0; r < NUM_REGS; r++) begin
                shadow[t][r] = '0;
            end
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        read_all_regs();

        // random contents with dma_on kept low
        for (t = 0; t < NUM_TILES; t++) begin
            for (r = 0; r < NUM_REGS; r++) begin
                d = next_rand();
                if (r == 0) begin
                    d[0] = 1'b0;
                end
                write_reg(t, r, d);
            end
        end
        repeat (16) begin
            t = int'(next_rand() % NUM_TILES);
            r = int'(next_rand() % NUM_REGS);
            d = next_rand();
            if (r == 0) begin
                d[0] = 1'b0;
            end
            write_reg(t, r, d);
        end
        read_all_regs();

        // unmapped words then isolation between tiles
        for (t = 0; t < NUM_TILES; t++) begin
            read_check(t, NUM_REGS + int'(next_rand() % (32 - NUM_REGS)));
        end
        write_reg(2, 1, next_rand());
        write_reg(9, 0, 32'h1);
        read_all_regs();

        // two valid entries per tile before dma_on
        for (t = 0; t < NUM_TILES; t++) begin
            for (e = 0; e < `GLB_QUEUE_DEPTH; e++) begin
                write_reg(t, 1 + 2 * e, (next_rand() % 32'd6) + 32'd1);
                d = next_rand();
                d[0] = 1'b1;
                write_reg(t, 2 + 2 * e, d);
                queue_entry_addrs(t, e);
            end
        end
        for (t = 0; t < NUM_TILES; t++) begin
            write_reg(t, 0, 32'h1);
        end
        wait_dma_drain();
        repeat (4) @(posedge clk);
        for (t = 0; t < NUM_TILES; t++) begin
            for (e = 0; e < `GLB_QUEUE_DEPTH; e++) begin
                shadow[t][2 + 2 * e][0] = 1'b0;
            end
        end
        read_all_regs();

        // empty entry 0 retired at once while entry 1 stays invalid
        for (t = 0; t < NUM_TILES; t++) begin
            write_reg(t, 1, 32'h0);
            d = next_rand();
            d[0] = 1'b1;
            write_reg(t, 2, d);
            write_reg(t, 3, 32'h5);
            d = next_rand();
            d[0] = 1'b0;
            write_reg(t, 4, d);
            shadow[t][2][0] = 1'b0;
        end
        repeat (20) @(posedge clk);
        read_all_regs();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/global_buffer_pkg.sv
verilog/glb_tile_cfg.sv
verilog/glb_cfg_router.sv
verilog/glb_ld_dma.sv
verilog/glb_tile.sv
verilog/glb_tile_array.sv
verification/glb_tile_array_props.sv
verification/tb_glb_tile_array.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tile array testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module tb_glb_tile_array \
    --Mdir "$build_dir" -o tb_glb_tile_array \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_glb_tile_array" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
fi

if grep -q "^TEST PASS$" "$log_file"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
